//--- rtl/gbCorePkg.sv
package gbCorePkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  typedef logic [7:0]  byteT;
  typedef logic [15:0] addrT;
  typedef logic [2:0]  regCodeT;
  typedef logic [3:0]  aluOpT;
  typedef logic [3:0]  flagsT;    // Z N H C, Z in the top bit

  // --------------------------------------------------
  // Register codes as they sit in opcode fields
  // --------------------------------------------------
  localparam regCodeT regB   = 3'd0;
  localparam regCodeT regC   = 3'd1;
  localparam regCodeT regD   = 3'd2;
  localparam regCodeT regE   = 3'd3;
  localparam regCodeT regH   = 3'd4;
  localparam regCodeT regL   = 3'd5;
  localparam regCodeT regMem = 3'd6;  // (HL)
  localparam regCodeT regA   = 3'd7;

  // --------------------------------------------------
  // ALU operations
  // --------------------------------------------------
  // First eight match opcode bits 5:3 of the 10xxxrrr group
  localparam aluOpT aluAdd  = 4'd0;
  localparam aluOpT aluAdc  = 4'd1;
  localparam aluOpT aluSub  = 4'd2;
  localparam aluOpT aluSbc  = 4'd3;
  localparam aluOpT aluAnd  = 4'd4;
  localparam aluOpT aluXor  = 4'd5;
  localparam aluOpT aluOr   = 4'd6;
  localparam aluOpT aluCp   = 4'd7;
  localparam aluOpT aluInc  = 4'd8;
  localparam aluOpT aluDec  = 4'd9;
  localparam aluOpT aluPass = 4'd10;  // Loads

  // Carry position inside flagsT
  localparam int flagC = 0;

  // Z=1 N=0 H=1 C=1
  localparam flagsT flagsResetValue = 4'b1011;

endpackage

//--- rtl/gbSequencer.sv
`timescale 1ns/1ps

module gbSequencer
  import gbCorePkg::*;
#(
  parameter addrT resetPc = '0
)
(
  input  logic    iClock,
  input  logic    rstN,
  input  byteT    memRdData,
  input  byteT    regH,
  input  byteT    regL,
  output addrT    memAddr,
  output logic    memRead,
  output logic    memWrite,
  output regCodeT rdSelA,
  output regCodeT rdSelB,
  output logic    wrEn,
  output regCodeT wrSel,
  output aluOpT   aluOp,
  output logic    aluEn,
  output byteT    imm
);

  typedef enum logic [2:0] {fetch, decode, immediate, store, halt} stateT;

  stateT   state;
  stateT   nextState;
  addrT    pc;
  regCodeT dstReg;     // LD r,n target, or the source of a store
  regCodeT holdCode;
  logic    holdEn;
  regCodeT dstField;
  regCodeT srcField;

  assign dstField = memRdData[5:3];
  assign srcField = memRdData[2:0];
  assign imm      = memRdData;   // Operand byte while in immediate

  // --------------------------------------------------
  // Decode and bus control
  // --------------------------------------------------
  always_comb
  begin
    nextState = state;
    memAddr   = pc;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    rdSelA    = dstReg;
    rdSelB    = srcField;
    wrEn      = 1'b0;
    wrSel     = dstField;
    aluOp     = aluPass;
    aluEn     = 1'b0;
    holdEn    = 1'b0;
    holdCode  = dstField;
    case (state)
      fetch:
      begin
        memRead   = rstN;          // Quiet while in reset
        nextState = decode;
      end
      decode:
      begin
        nextState = fetch;
        casez (memRdData)
          8'h76:
            nextState = halt;
          8'b01110???:               // LD (HL),r
          begin
            holdEn    = 1'b1;
            holdCode  = srcField;
            nextState = store;
          end
          8'b01??????:               // LD r,r'
            wrEn = (srcField != regMem);
          8'b10??????:
          begin
            aluOp = {1'b0, memRdData[5:3]};
            aluEn = (srcField != regMem);
            wrEn  = (srcField != regMem);
            wrSel = regA;
          end
          8'b00???110:               // LD r,n
          begin
            if (dstField != regMem)
            begin
              memRead   = 1'b1;
              holdEn    = 1'b1;
              nextState = immediate;
            end
          end
          8'b00???10?:               // INC r / DEC r
          begin
            rdSelB = dstField;
            aluOp  = memRdData[0] ? aluDec : aluInc;
            aluEn  = (dstField != regMem);
            wrEn   = (dstField != regMem);
          end
          default:
            nextState = fetch;
        endcase
      end
      immediate:
      begin
        wrEn      = 1'b1;
        wrSel     = dstReg;
        aluEn     = 1'b1;          // Pass selects imm, flags kept
        nextState = fetch;
      end
      store:
      begin
        memAddr   = {regH, regL};
        memWrite  = 1'b1;
        nextState = fetch;
      end
      halt:
        nextState = halt;
      default:
        nextState = fetch;
    endcase
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      state  <= fetch;
      pc     <= resetPc;
      dstReg <= regMem;
    end
    else
    begin
      state <= nextState;
      if (memRead)
        pc <= pc + 16'd1;      // One step per byte read
      if (holdEn)
        dstReg <= holdCode;
    end
  end

endmodule

//--- rtl/gbRegFile.sv
`timescale 1ns/1ps

module gbRegFile
  import gbCorePkg::*;
(
  input  logic    iClock,
  input  logic    rstN,
  input  logic    wrEn,
  input  regCodeT wrSel,
  input  byteT    wrData,
  input  regCodeT rdSelA,
  input  regCodeT rdSelB,
  output byteT    rdDataA,
  output byteT    rdDataB,
  output byteT    regA,
  output byteT    regH,
  output byteT    regL
);

  // Indexed by register code, slot regMem is never written and reads zero
  byteT regs [8];

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      for (int i = 0; i < 8; i++)
        regs[i] <= '0;
    end
    else if (wrEn && wrSel != regMem)
    begin
      regs[wrSel] <= wrData;
    end
  end

  assign rdDataA = regs[rdSelA];
  assign rdDataB = regs[rdSelB];

  // Fixed taps for the accumulator and the HL pair
  assign regA = regs[gbCorePkg::regA];
  assign regH = regs[gbCorePkg::regH];
  assign regL = regs[gbCorePkg::regL];

endmodule

//--- rtl/gbAlu.sv
`timescale 1ns/1ps

module gbAlu
  import gbCorePkg::*;
(
  input  logic  iClock,
  input  logic  rstN,
  input  aluOpT aluOp,
  input  logic  aluEn,
  input  byteT  acc,
  input  byteT  operand,
  input  byteT  imm,
  output byteT  result
);

  flagsT      flags;
  flagsT      nextFlags;
  logic       carryIn;
  logic [8:0] addWide;
  logic [8:0] subWide;
  logic [4:0] addNib;
  logic [4:0] subNib;
  byteT       incVal;
  byteT       decVal;

  assign carryIn = (aluOp == aluAdc || aluOp == aluSbc) ? flags[flagC] : 1'b0;

  assign addWide = {1'b0, acc} + {1'b0, operand} + {8'b0, carryIn};
  assign addNib  = {1'b0, acc[3:0]} + {1'b0, operand[3:0]} + {4'b0, carryIn};
  assign subWide = {1'b0, acc} - {1'b0, operand} - {8'b0, carryIn};  // Bit 8 is borrow
  assign subNib  = {1'b0, acc[3:0]} - {1'b0, operand[3:0]} - {4'b0, carryIn};
  assign incVal  = operand + 8'd1;
  assign decVal  = operand - 8'd1;

  // --------------------------------------------------
  // Result and flag select
  // --------------------------------------------------
  always_comb
  begin
    result    = operand;
    nextFlags = flags;
    case (aluOp)
      aluAdd, aluAdc:
      begin
        result    = addWide[7:0];
        nextFlags = {addWide[7:0] == 8'd0, 1'b0, addNib[4], addWide[8]};
      end
      aluSub, aluSbc, aluCp:
      begin
        result    = (aluOp == aluCp) ? acc : subWide[7:0];  // CP leaves A alone
        nextFlags = {subWide[7:0] == 8'd0, 1'b1, subNib[4], subWide[8]};
      end
      aluAnd:
      begin
        result    = acc & operand;
        nextFlags = {(acc & operand) == 8'd0, 3'b010};
      end
      aluXor:
      begin
        result    = acc ^ operand;
        nextFlags = {(acc ^ operand) == 8'd0, 3'b000};
      end
      aluOr:
      begin
        result    = acc | operand;
        nextFlags = {(acc | operand) == 8'd0, 3'b000};
      end
      aluInc:
      begin
        result    = incVal;
        nextFlags = {incVal == 8'd0, 1'b0, operand[3:0] == 4'hF, flags[flagC]};
      end
      aluDec:
      begin
        result    = decVal;
        nextFlags = {decVal == 8'd0, 1'b1, operand[3:0] == 4'h0, flags[flagC]};
      end
      aluPass:
        result = aluEn ? imm : operand;  // Strobed pass is LD r,n
      default:
        result = operand;
    endcase
  end

  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
      flags <= flagsResetValue;
    else if (aluEn)
      flags <= nextFlags;
  end

endmodule

//--- rtl/gbCore.sv
`timescale 1ns/1ps

module gbCore
  import gbCorePkg::*;
#(
  parameter addrT resetPc = '0
)
(
  input  logic iClock,
  input  logic rstN,
  input  byteT memRdData,
  output addrT memAddr,
  output logic memRead,
  output logic memWrite,
  output byteT memWrData
);

  regCodeT rdSelA;
  regCodeT rdSelB;
  regCodeT wrSel;
  logic    wrEn;
  logic    aluEn;
  aluOpT   aluOp;
  byteT    imm;
  byteT    result;
  byteT    operand;
  byteT    regA;
  byteT    regH;
  byteT    regL;

  // --------------------------------------------------
  // Control, state and datapath
  // --------------------------------------------------
  gbSequencer #(.resetPc(resetPc)) sequencer
  (
    .iClock   (iClock),
    .rstN     (rstN),
    .memRdData(memRdData),
    .regH     (regH),
    .regL     (regL),
    .memAddr  (memAddr),
    .memRead  (memRead),
    .memWrite (memWrite),
    .rdSelA   (rdSelA),
    .rdSelB   (rdSelB),
    .wrEn     (wrEn),
    .wrSel    (wrSel),
    .aluOp    (aluOp),
    .aluEn    (aluEn),
    .imm      (imm)
  );

  gbRegFile regFile
  (
    .iClock (iClock),
    .rstN   (rstN),
    .wrEn   (wrEn),
    .wrSel  (wrSel),
    .wrData (result),
    .rdSelA (rdSelA),
    .rdSelB (rdSelB),
    .rdDataA(memWrData),   // Store data
    .rdDataB(operand),
    .regA   (regA),
    .regH   (regH),
    .regL   (regL)
  );

  gbAlu alu
  (
    .iClock (iClock),
    .rstN   (rstN),
    .aluOp  (aluOp),
    .aluEn  (aluEn),
    .acc    (regA),
    .operand(operand),
    .imm    (imm),
    .result (result)
  );

endmodule

//--- bench/gbCore_checker.sv
`timescale 1ns/1ps

module gbCoreChecker
  import gbCorePkg::*;
#(
  parameter addrT resetPc = '0
)
(
  input logic iClock,
  input logic rstN,
  input logic memRead,
  input logic memWrite,
  input addrT memAddr,
  input byteT memRdData
);

  logic rdPending;       // Read issued last cycle
  logic opcodePending;   // That read was an opcode fetch
  logic halted;
  int   failures = 0;

  // Operand reads are the only reads issued while a response arrives
  always_ff @(posedge iClock or negedge rstN)
  begin
    if (!rstN)
    begin
      rdPending     <= 1'b0;
      opcodePending <= 1'b0;
      halted        <= 1'b0;
    end
    else
    begin
      rdPending     <= memRead;
      opcodePending <= memRead && !rdPending;
      if (opcodePending && memRdData == 8'h76)
        halted <= 1'b1;
    end
  end

  // --------------------------------------------------
  // Bus protocol
  // --------------------------------------------------
  strobesExclusive: assert property (@(posedge iClock) !(memRead && memWrite))
  else
  begin
    failures++;
    $error("memRead and memWrite high in the same cycle");
  end

  quietInReset: assert property (@(posedge iClock) !rstN |-> (!memRead && !memWrite))
  else
  begin
    failures++;
    $error("bus strobe high while in reset");
  end

  // First cycle out of reset fetches at the reset PC
  firstRead: assert property (@(posedge iClock)
    $rose(rstN) |-> (memRead && memAddr == resetPc))
  else
  begin
    failures++;
    $error("first cycle after reset is not a read at the reset PC");
  end

  quietAfterHalt: assert property (@(posedge iClock) disable iff (!rstN)
    halted |-> (!memRead && !memWrite))
  else
  begin
    failures++;
    $error("bus strobe raised after HALT");
  end

endmodule

bind gbCore gbCoreChecker #(.resetPc(resetPc)) busChecker
(
  .iClock   (iClock),
  .rstN     (rstN),
  .memRead  (memRead),
  .memWrite (memWrite),
  .memAddr  (memAddr),
  .memRdData(memRdData)
);

//--- bench/gbCoreTb.sv
`timescale 1ns/1ps

module gbCoreTb
  import gbCorePkg::*;
();

  localparam addrT resetPc         = 16'h0004;
  localparam int   afterHaltCycles = 16;

  logic        iClock;
  logic        rstN;
  byteT        memRdData;
  addrT        memAddr;
  logic        memRead;
  logic        memWrite;
  byteT        memWrData;

  byteT        mem [256];
  byteT        model [8];     // Expected register contents by register code
  logic        modelCarry;
  addrT        expAddr [$];
  byteT        expData [$];
  addrT        wantAddr;
  byteT        wantData;
  addrT        nextRead;
  addrT        haltAddr;
  logic        haltSeen;
  logic [31:0] rngState;
  int          buildPtr;
  int          instrCount;
  byteT        resultSlot;
  int          mismatchCount;
  int          otherCount;
  int          cycles;
  int          cycleLimit;
  int          quietCycles;

  gbCore #(.resetPc(resetPc)) DUT
  (
    .iClock   (iClock),
    .rstN     (rstN),
    .memRdData(memRdData),
    .memAddr  (memAddr),
    .memRead  (memRead),
    .memWrite (memWrite),
    .memWrData(memWrData)
  );

  initial
  begin
    iClock = 1'b0;
    forever #20 iClock = ~iClock;
  end

  // --------------------------------------------------
  // Program builder and reference model
  // --------------------------------------------------
  function automatic byteT nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[7:0];
  endfunction

  task automatic emit(input byteT value);
    mem[buildPtr] = value;
    buildPtr++;
  endtask

  task automatic loadImm(input regCodeT dst, input byteT value);
    emit({2'b00, dst, 3'b110});
    emit(value);
    instrCount++;
    model[dst] = value;
  endtask

  task automatic copyReg(input regCodeT dst, input regCodeT src);
    emit({2'b01, dst, src});
    instrCount++;
    model[dst] = model[src];
  endtask

  task automatic stepReg(input regCodeT dst, input logic down);
    emit({2'b00, dst, 2'b10, down});
    instrCount++;
    model[dst] = down ? model[dst] - 8'd1 : model[dst] + 8'd1;  // C untouched
  endtask

  task automatic runAlu(input aluOpT op, input regCodeT src);
    int   a;
    int   b;
    int   cin;
    int   res;
    logic carry;
    a     = model[regA];
    b     = model[src];
    cin   = (op == aluAdc || op == aluSbc) ? modelCarry : 0;
    res   = a;
    carry = 1'b0;               // Logic ops clear C
    emit({2'b10, op[2:0], src});
    instrCount++;
    case (op)
      aluAdd, aluAdc:
      begin
        res   = a + b + cin;
        carry = res > 255;
      end
      aluSub, aluSbc, aluCp:
      begin
        res   = a - b - cin;
        carry = res < 0;        // Borrow
      end
      aluAnd:
        res = a & b;
      aluXor:
        res = a ^ b;
      aluOr:
        res = a | b;
      default:
        res = a;
    endcase
    modelCarry = carry;
    if (op != aluCp)
      model[regA] = byteT'(res);
  endtask

  task automatic skipOp(input byteT opcode);
    emit(opcode);
    instrCount++;
  endtask

  task automatic storeReg(input regCodeT src);
    loadImm(regL, resultSlot);
    resultSlot++;
    emit({5'b01110, src});
    instrCount++;
    expAddr.push_back({model[regH], model[regL]});
    expData.push_back(model[src]);
  endtask

  task automatic haltCore();
    haltAddr = addrT'(buildPtr);
    emit(8'h76);
    instrCount++;
  endtask

  task automatic buildProgram();
    regCodeT loadOrder [5] = '{regB, regC, regD, regE, regA};
    aluOpT   aluOrder [5]  = '{aluAdd, aluSub, aluAnd, aluXor, aluOr};
    runAlu(aluAdc, regB);       // Sees the reset carry
    loadImm(regH, 8'h00);       // Result area in page zero
    storeReg(regA);
    foreach (loadOrder[i])
      loadImm(loadOrder[i], nextRandom());
    foreach (loadOrder[i])
      storeReg(loadOrder[i]);
    storeReg(regH);
    storeReg(regL);
    copyReg(regD, regB);
    copyReg(regE, regA);
    copyReg(regA, regC);
    storeReg(regD);
    storeReg(regE);
    storeReg(regA);
    foreach (aluOrder[i])
    begin
      loadImm(regA, nextRandom());
      loadImm(regB, nextRandom());
      runAlu(aluOrder[i], regB);
      storeReg(regA);
    end
    loadImm(regA, nextRandom());
    loadImm(regC, nextRandom());
    runAlu(aluCp, regC);
    storeReg(regA);
    runAlu(aluXor, regA);
    skipOp(8'h00);
    skipOp(8'h86);              // ALU with (HL) source
    skipOp(8'h34);              // INC (HL)
    storeReg(regA);
    // Carry chains
    loadImm(regA, 8'hFF);
    loadImm(regB, 8'h01);
    runAlu(aluAdd, regB);
    loadImm(regA, nextRandom());
    runAlu(aluAdc, regB);
    storeReg(regA);
    loadImm(regA, 8'hFF);
    runAlu(aluAdd, regB);
    loadImm(regA, nextRandom());
    runAlu(aluSbc, regB);
    storeReg(regA);
    loadImm(regA, 8'hFF);
    runAlu(aluAdd, regB);
    loadImm(regC, 8'hFF);
    stepReg(regC, 1'b0);
    loadImm(regD, 8'h00);
    stepReg(regD, 1'b1);
    loadImm(regA, nextRandom());
    runAlu(aluAdc, regB);
    storeReg(regA);
    storeReg(regC);
    storeReg(regD);
    runAlu(aluOr, regA);        // Now with C clear
    loadImm(regE, 8'hFF);
    stepReg(regE, 1'b0);
    loadImm(regD, 8'h00);
    stepReg(regD, 1'b1);
    loadImm(regA, nextRandom());
    runAlu(aluAdc, regB);
    storeReg(regA);
    storeReg(regE);
    storeReg(regD);
    haltCore();
  endtask

  // --------------------------------------------------
  // Memory model and checks
  // --------------------------------------------------
  always @(posedge iClock)
  begin
    if (memRead)
      memRdData <= mem[memAddr[7:0]];
    if (memWrite)
      mem[memAddr[7:0]] <= memWrData;
  end

  always @(posedge iClock)
  begin
    if (!rstN)
    begin
      nextRead <= resetPc;
      haltSeen <= 1'b0;
    end
    else
    begin
      if (memRead)
      begin
        assert (memAddr == nextRead)
        else
        begin
          mismatchCount++;
          $display("mismatch at time %0t: memAddr expected %h, got %h",
                   $time, nextRead, memAddr);
        end
        nextRead <= nextRead + 16'd1;
        if (memAddr == haltAddr)
          haltSeen <= 1'b1;
      end
      if (memWrite)
      begin
        assert (expData.size() > 0)
        else
        begin
          otherCount++;
          $display("store at time %0t to address %h was not expected", $time, memAddr);
        end
        if (expData.size() > 0)
        begin
          wantAddr = expAddr.pop_front();
          wantData = expData.pop_front();
          assert (memAddr == wantAddr)
          else
          begin
            mismatchCount++;
            $display("mismatch at time %0t: memAddr expected %h, got %h",
                     $time, wantAddr, memAddr);
          end
          assert (memWrData == wantData)
          else
          begin
            mismatchCount++;
            $display("mismatch at time %0t: memWrData expected %h, got %h",
                     $time, wantData, memWrData);
          end
        end
      end
    end
  end

  initial
  begin
    rstN          = 1'b0;
    memRdData     = '0;
    rngState      = 32'd65;
    buildPtr      = int'(resetPc);
    resultSlot    = 8'hC0;
    instrCount    = 0;
    modelCarry    = 1'b1;       // Flags reset with C set
    mismatchCount = 0;
    otherCount    = 0;
    cycles        = 0;
    quietCycles   = 0;
    for (int i = 0; i < 256; i++)
      mem[i] = byteT'(i) ^ 8'hA5;
    foreach (model[i])
      model[i] = 8'h00;
    buildProgram();
    assert (buildPtr <= 'hC0)
    else
    begin
      otherCount++;
      $display("program runs into the result area");
    end
    cycleLimit = 3 * instrCount + 64;
    repeat (16) @(posedge iClock);
    rstN <= 1'b1;
    while (quietCycles < afterHaltCycles && cycles < cycleLimit)
    begin
      @(posedge iClock);
      cycles++;
      if (haltSeen)
        quietCycles++;
    end
    if (quietCycles < afterHaltCycles)
    begin
      otherCount++;
      $display("timeout: core did not reach HALT within %0d cycles", cycleLimit);
    end
    assert (expData.size() == 0)
    else
    begin
      otherCount++;
      $display("%0d expected stores never happened", expData.size());
    end
    $display("errors: %0d mismatch, %0d other, %0d bus checker",
             mismatchCount, otherCount, DUT.busChecker.failures);
    if (mismatchCount + otherCount + DUT.busChecker.failures == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- vlog.f
rtl/gbCorePkg.sv
rtl/gbSequencer.sv
rtl/gbRegFile.sv
rtl/gbAlu.sv
rtl/gbCore.sv
bench/gbCore_checker.sv
bench/gbCoreTb.sv

//--- Bender.yml
package:
  name: gb_core

sources:
  # Package first, then the core
  - rtl/gbCorePkg.sv
  - rtl/gbSequencer.sv
  - rtl/gbRegFile.sv
  - rtl/gbAlu.sv
  - rtl/gbCore.sv

  # Testbench with bound checker
  - target: test
    files:
      - bench/gbCore_checker.sv
      - bench/gbCoreTb.sv
